// File: dv/spu_regfile_properties.sv
// Concurrent checks on odd pipe flush and pc timing, plus the bind into the top level
`timescale 1ns/1ns
`default_nettype none

module spu_regfile_properties (
    input logic                        clk,
    input logic                        reset,
    input spu_regfile_pkg::odd_instr_t odd_instr,  // Sampled at the fetch edge
    input spu_regfile_pkg::odd_issue_t odd_issue   // Packet one cycle later
);
    int unsigned assert_errors = 0;  // Failure count, read at end of run

    // Flush request reaches the odd pipe one cycle later
    a_flush_follows: assert property (
        @(posedge clk) (!reset && odd_instr.flush) |=> odd_issue.flush
    ) else begin
        assert_errors++;
        $error("flush on odd_instr missing from odd_issue one cycle later");
    end

    // Reset clears the packet, so no stale kill leaks out
    a_flush_cleared: assert property (
        @(posedge clk) reset |=> !odd_issue.flush
    ) else begin
        assert_errors++;
        $error("odd_issue flush high in the cycle after reset");
    end

    // Branch pc rides along with its instruction
    a_pc_follows: assert property (
        @(posedge clk) !reset |=> (odd_issue.pc == $past(odd_instr.pc))
    ) else begin
        assert_errors++;
        $error("odd_issue pc differs from previous odd_instr pc");
    end

endmodule

bind spu_regfile_top spu_regfile_properties i_properties (
    .clk       (clk),
    .reset     (reset),
    .odd_instr (odd_instr),
    .odd_issue (odd_issue)
);

`default_nettype wire

// File: dv/tb_spu_regfile.sv
// Directed testbench for the dual-pipe register file with LFSR data, watchdog and summary
`timescale 1ns/1ns
`default_nettype none

module tb_spu_regfile;
    import spu_regfile_pkg::*;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 3;
    localparam int PRELOAD_SLOTS = 7;   // Rows 12..14 and constants 124..127
    localparam int XPIPE_PAIRS   = 4;   // Write pairs in the cross-pipe test
    localparam int ALIGN_CYCLES  = 8;
    // Sum of all test lengths in cycles
    localparam int TEST_CYCLES   = RESET_CYCLES + 1 + PRELOAD_SLOTS + 2 * XPIPE_PAIRS + 3 + 2
                                   + ALIGN_CYCLES;
    localparam int MARGIN_CYCLES = 50;
    localparam int WATCHDOG_NS   = (TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

    logic        clk;
    logic        reset;
    even_instr_t even_instr;
    odd_instr_t  odd_instr;
    writeback_t  even_wb;
    writeback_t  odd_wb;
    even_issue_t even_issue;
    odd_issue_t  odd_issue;

    logic [31:0]  lfsr_state   = 32'h9a1d315f;  // Fixed seed
    logic [127:0] used_regs    = '0;            // Registers already claimed by a test
    string        cur_test     = "";
    int           checks       = 0;
    int           errors       = 0;
    int           tests_run    = 0;
    int           tests_failed = 0;

    spu_regfile_top i_dut (
        .clk        (clk),
        .reset      (reset),
        .even_instr (even_instr),
        .odd_instr  (odd_instr),
        .even_wb    (even_wb),
        .odd_wb     (odd_wb),
        .even_issue (even_issue),
        .odd_issue  (odd_issue)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;  // 40 ns period

    // One bit per call from x^32 + x^22 + x^2 + x + 1
    function automatic logic next_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [127:0] rand_bits(input int n);
        logic [127:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[126:0], next_bit()};  // Low n bits filled
        end
        return r;
    endfunction

    function automatic logic is_preload(input reg_addr_t a);
        return (a >= 7'd12 && a <= 7'd14) || (a >= 7'd124);
    endfunction

    // Reset contents of the preloaded registers
    function automatic quad_t preload_value(input reg_addr_t a);
        case (a)
            7'd12:   return PRELOAD_ROW_A;
            7'd13:   return PRELOAD_ROW_B1;
            7'd14:   return PRELOAD_ROW_B2;
            7'd124:  return PRELOAD_CONST_124;
            7'd125:  return PRELOAD_CONST_125;
            7'd126:  return PRELOAD_CONST_126;
            default: return PRELOAD_CONST_127;
        endcase
    endfunction

    task automatic step();
        @(negedge clk);  // Outputs settled and safe to drive
    endtask

    task automatic clear_inputs();
        even_instr = '0;
        odd_instr  = '0;
        even_wb    = '0;
        odd_wb     = '0;
    endtask

    // Random free register outside the preload set
    task automatic pick_addr(output reg_addr_t a);
        reg_addr_t cand;
        cand = rand_bits(7);
        while (is_preload(cand) || used_regs[cand]) begin
            cand = rand_bits(7);
        end
        used_regs[cand] = 1'b1;
        a = cand;
    endtask

    task automatic check_value(input string what, input logic [127:0] exp,
                               input logic [127:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic finish_test(input int start);
        int n;
        n = errors - start;
        tests_run++;
        if (n == 0) begin
            $display("%s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("%s: %0d error(s)", cur_test, n);
        end
    endtask

    task automatic test_preload();
        reg_addr_t addrs [0:PRELOAD_SLOTS-1];
        int        start;
        start    = errors;
        cur_test = "preload";
        addrs    = '{7'd12, 7'd13, 7'd14, 7'd124, 7'd125, 7'd126, 7'd127};
        for (int i = 0; i < PRELOAD_SLOTS; i++) begin
            // Rotate so every slot passes through every port
            even_instr.src = '{addrs[i], addrs[(i + 1) % 7], addrs[(i + 2) % 7]};
            odd_instr.src  = '{addrs[(i + 3) % 7], addrs[(i + 4) % 7], addrs[(i + 5) % 7]};
            step();
            check_value("even ra", preload_value(addrs[i]), even_issue.operands.ra_data);
            check_value("even rb", preload_value(addrs[(i + 1) % 7]),
                        even_issue.operands.rb_data);
            check_value("even rc", preload_value(addrs[(i + 2) % 7]),
                        even_issue.operands.rc_data);
            check_value("odd ra", preload_value(addrs[(i + 3) % 7]), odd_issue.operands.ra_data);
            check_value("odd rb", preload_value(addrs[(i + 4) % 7]), odd_issue.operands.rb_data);
            check_value("odd rc", preload_value(addrs[(i + 5) % 7]), odd_issue.operands.rc_data);
        end
        finish_test(start);
    endtask

    task automatic test_cross_pipe();
        reg_addr_t even_addr [0:XPIPE_PAIRS-1];
        reg_addr_t odd_addr  [0:XPIPE_PAIRS-1];
        quad_t     even_data [0:XPIPE_PAIRS-1];
        quad_t     odd_data  [0:XPIPE_PAIRS-1];
        int        start;
        int        j;
        int        k;
        start    = errors;
        cur_test = "cross_pipe";
        for (int i = 0; i < XPIPE_PAIRS; i++) begin
            pick_addr(even_addr[i]);
            pick_addr(odd_addr[i]);
            even_data[i] = rand_bits(128);
            odd_data[i]  = rand_bits(128);
            even_wb      = '{1'b1, even_addr[i], even_data[i]};
            odd_wb       = '{1'b1, odd_addr[i], odd_data[i]};
            step();                                   // Both written at this edge
        end
        even_wb = '0;
        odd_wb  = '0;
        for (int i = 0; i < XPIPE_PAIRS; i++) begin
            j = (i + 1) % XPIPE_PAIRS;
            k = (i + 2) % XPIPE_PAIRS;
            even_instr.src = '{odd_addr[i], odd_addr[j], odd_addr[k]};    // Odd results
            odd_instr.src  = '{even_addr[i], even_addr[j], even_addr[k]}; // Even results
            step();
            check_value("even ra", odd_data[i], even_issue.operands.ra_data);
            check_value("even rb", odd_data[j], even_issue.operands.rb_data);
            check_value("even rc", odd_data[k], even_issue.operands.rc_data);
            check_value("odd ra", even_data[i], odd_issue.operands.ra_data);
            check_value("odd rb", even_data[j], odd_issue.operands.rb_data);
            check_value("odd rc", even_data[k], odd_issue.operands.rc_data);
        end
        finish_test(start);
    endtask

    task automatic test_read_during_write();
        reg_addr_t a;
        quad_t     old_data;
        quad_t     new_data;
        int        start;
        start    = errors;
        cur_test = "read_during_write";
        pick_addr(a);
        old_data = rand_bits(128);
        new_data = rand_bits(128);
        even_wb  = '{1'b1, a, old_data};
        step();
        even_wb        = '{1'b1, a, new_data};  // Write and read share this edge
        even_instr.src = '{a, a, a};
        odd_instr.src  = '{a, a, a};
        step();
        check_value("even ra same edge", old_data, even_issue.operands.ra_data);
        check_value("odd rc same edge", old_data, odd_issue.operands.rc_data);
        even_wb = '0;
        step();                                 // Read one cycle later
        check_value("even ra next edge", new_data, even_issue.operands.ra_data);
        check_value("odd rb next edge", new_data, odd_issue.operands.rb_data);
        finish_test(start);
    endtask

    task automatic test_collision();
        reg_addr_t a;
        quad_t     even_data;
        quad_t     odd_data;
        int        start;
        start    = errors;
        cur_test = "collision";
        pick_addr(a);
        even_data = rand_bits(128);
        odd_data  = rand_bits(128);
        if (odd_data == even_data) begin
            odd_data = ~even_data;  // Keep the two writes apart
        end
        even_wb = '{1'b1, a, even_data};
        odd_wb  = '{1'b1, a, odd_data};
        step();
        even_wb        = '0;
        odd_wb         = '0;
        even_instr.src = '{a, a, a};
        odd_instr.src  = '{a, a, a};
        step();
        check_value("even ra", odd_data, even_issue.operands.ra_data);  // Odd port wins
        check_value("odd rb", odd_data, odd_issue.operands.rb_data);
        finish_test(start);
    endtask

    task automatic test_field_alignment();
        logic [127:0] r;
        even_instr_t  e;
        odd_instr_t   o;
        int           start;
        start    = errors;
        cur_test = "field_alignment";
        for (int i = 0; i < ALIGN_CYCLES; i++) begin
            r          = rand_bits(90);
            e          = r[89:0];
            r          = rand_bits(106);
            o          = r[105:0];       // Includes random pc and flush
            even_instr = e;
            odd_instr  = o;
            step();
            check_value("even opcode", e.opcode, even_issue.opcode);
            check_value("even rt", e.rt, even_issue.rt);
            check_value("even imm7", e.imm7, even_issue.imm7);
            check_value("even imm10", e.imm10, even_issue.imm10);
            check_value("even imm16", e.imm16, even_issue.imm16);
            check_value("even imm18", e.imm18, even_issue.imm18);
            check_value("odd opcode", o.opcode, odd_issue.opcode);
            check_value("odd rt", o.rt, odd_issue.rt);
            check_value("odd imm7", o.imm7, odd_issue.imm7);
            check_value("odd imm10", o.imm10, odd_issue.imm10);
            check_value("odd imm16", o.imm16, odd_issue.imm16);
            check_value("odd imm18", o.imm18, odd_issue.imm18);
            check_value("odd pc", o.pc, odd_issue.pc);
            check_value("odd flush", o.flush, odd_issue.flush);
        end
        finish_test(start);
    endtask

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int prop_errors;
        clk   = 1'b0;
        reset = 1'b1;
        clear_inputs();
        odd_instr.flush = 1'b1;                // Kill request held through reset
        repeat (RESET_CYCLES) @(posedge clk);  // Preload loads on each of these edges
        @(negedge clk);
        reset = 1'b0;
        clear_inputs();
        test_preload();
        test_cross_pipe();
        test_read_during_write();
        test_collision();
        test_field_alignment();
        clear_inputs();
        step();                                // Let the last concurrent checks fire
        prop_errors = i_dut.i_properties.assert_errors;
        $display("tests %0d, failed tests %0d, checks %0d, errors %0d, property failures %0d",
                 tests_run, tests_failed, checks, errors, prop_errors);
        if (errors == 0 && prop_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/operand_fetch.sv
// Operand fetch stage registering instruction fields and read operands into issue packets
`timescale 1ns/1ns
`default_nettype none

module operand_fetch (
    input  logic                           clk,
    input  logic                           reset,
    input  spu_regfile_pkg::even_instr_t   even_instr,     // From issue
    input  spu_regfile_pkg::odd_instr_t    odd_instr,      // From issue
    output spu_regfile_pkg::operand_addr_t even_src,       // To array read ports
    output spu_regfile_pkg::operand_addr_t odd_src,
    input  spu_regfile_pkg::operand_data_t even_operands,  // Back from array
    input  spu_regfile_pkg::operand_data_t odd_operands,
    output spu_regfile_pkg::even_issue_t   even_issue,     // To even pipe
    output spu_regfile_pkg::odd_issue_t    odd_issue       // To odd pipe
);
    import spu_regfile_pkg::*;

    even_issue_t even_issue_d;  // Packet being assembled this cycle
    odd_issue_t  odd_issue_d;

    // Address side
    // Source fields go straight to the array, data comes back in the same cycle
    assign even_src = even_instr.src;
    assign odd_src  = odd_instr.src;

    // Even packet assembly
    always_comb begin
        even_issue_d.opcode   = even_instr.opcode;
        even_issue_d.rt       = even_instr.rt;      // Destination for later write-back
        even_issue_d.imm7     = even_instr.imm7;
        even_issue_d.imm10    = even_instr.imm10;
        even_issue_d.imm16    = even_instr.imm16;
        even_issue_d.imm18    = even_instr.imm18;
        even_issue_d.operands = even_operands;      // Values before this edge
    end

    // Odd packet assembly
    // Same fields as even plus branch PC and flush
    always_comb begin
        odd_issue_d.opcode   = odd_instr.opcode;
        odd_issue_d.rt       = odd_instr.rt;
        odd_issue_d.imm7     = odd_instr.imm7;
        odd_issue_d.imm10    = odd_instr.imm10;
        odd_issue_d.imm16    = odd_instr.imm16;
        odd_issue_d.imm18    = odd_instr.imm18;
        odd_issue_d.operands = odd_operands;
        odd_issue_d.pc       = odd_instr.pc;        // Carried for branch resolve
        odd_issue_d.flush    = odd_instr.flush;
    end

    // Issue registers
    // One packet per pipe per cycle, overwritten by the next instruction.
    // Fields and operands are captured on the same edge so they stay paired.
    always_ff @(posedge clk) begin
        if (reset) begin
            even_issue <= '0;             // Null op into even pipe
            odd_issue  <= '0;             // Also drops any flush
        end else begin
            even_issue <= even_issue_d;
            odd_issue  <= odd_issue_d;
        end
    end

endmodule

`default_nettype wire

// File: hdl/register_array.sv
// Register array with reset preload, even and odd write-back ports and six operand reads
`timescale 1ns/1ns
`default_nettype none

module register_array (
    input  logic                           clk,
    input  logic                           reset,
    input  spu_regfile_pkg::writeback_t    even_wb,        // Even pipe result
    input  spu_regfile_pkg::writeback_t    odd_wb,         // Odd pipe result
    input  spu_regfile_pkg::operand_addr_t even_src,       // Even ra/rb/rc addresses
    input  spu_regfile_pkg::operand_addr_t odd_src,        // Odd ra/rb/rc addresses
    output spu_regfile_pkg::operand_data_t even_operands,  // Same-cycle read data
    output spu_regfile_pkg::operand_data_t odd_operands
);
    import spu_regfile_pkg::*;

    quad_t mem [0:NUM_REGS-1];  // Main storage

    // Preload slot addresses
    localparam reg_addr_t ADDR_ROW_B1   = PRELOAD_ADDR_ROW_A + 7'd1;
    localparam reg_addr_t ADDR_ROW_B2   = PRELOAD_ADDR_ROW_A + 7'd2;
    localparam reg_addr_t ADDR_CONST_0  = reg_addr_t'(NUM_REGS - 4);  // Register 124
    localparam reg_addr_t ADDR_CONST_1  = reg_addr_t'(NUM_REGS - 3);
    localparam reg_addr_t ADDR_CONST_2  = reg_addr_t'(NUM_REGS - 2);
    localparam reg_addr_t ADDR_CONST_3  = reg_addr_t'(NUM_REGS - 1);  // Register 127

    logic same_rt;  // Both pipes target one register

    assign same_rt = even_wb.wr_en && odd_wb.wr_en && (even_wb.rt == odd_wb.rt);

    // Write side
    // Reset reloads the seven preload slots each edge and holds off write-back.
    // Every other register simply keeps what it had.
    always_ff @(posedge clk) begin
        if (reset) begin
            mem[PRELOAD_ADDR_ROW_A] <= PRELOAD_ROW_A;      // Matrix A
            mem[ADDR_ROW_B1]        <= PRELOAD_ROW_B1;     // Matrix B, first row
            mem[ADDR_ROW_B2]        <= PRELOAD_ROW_B2;     // Matrix B, second row
            mem[ADDR_CONST_0]       <= PRELOAD_CONST_124;
            mem[ADDR_CONST_1]       <= PRELOAD_CONST_125;
            mem[ADDR_CONST_2]       <= PRELOAD_CONST_126;
            mem[ADDR_CONST_3]       <= PRELOAD_CONST_127;
        end else begin
            if (even_wb.wr_en && !same_rt) begin
                mem[even_wb.rt] <= even_wb.data;           // Dropped on collision
            end
            if (odd_wb.wr_en) begin
                mem[odd_wb.rt] <= odd_wb.data;             // Odd pipe wins ties
            end
        end
    end

    // Read side
    // Pure array lookup, so a write at this edge is not visible until after it
    always_comb begin
        even_operands.ra_data = mem[even_src.ra];
        even_operands.rb_data = mem[even_src.rb];
        even_operands.rc_data = mem[even_src.rc];
    end

    always_comb begin
        odd_operands.ra_data = mem[odd_src.ra];
        odd_operands.rb_data = mem[odd_src.rb];
        odd_operands.rc_data = mem[odd_src.rc];
    end

endmodule

`default_nettype wire

// File: hdl/spu_regfile_pkg.sv
// Register-file sizes, field types, issue packet structs and reset preload constants
`default_nettype none

package spu_regfile_pkg;

    // Register file geometry
    localparam int NUM_REGS      = 128;   // Architected vector registers
    localparam int QUAD_BITS     = 128;   // One quadword per register
    localparam int REG_ADDR_BITS = 7;     // log2 of NUM_REGS

    // Instruction field widths
    localparam int OPCODE_BITS = 11;      // Longest opcode form
    localparam int PC_BITS     = 15;      // Odd pipe branch PC

    typedef logic [0:REG_ADDR_BITS-1] reg_addr_t;
    typedef logic [0:QUAD_BITS-1]     quad_t;      // Bit 0 is the MSB, word 0 leftmost
    typedef logic [0:OPCODE_BITS-1]   opcode_t;
    typedef logic [0:PC_BITS-1]       pc_t;

    typedef logic signed [0:6]  imm7_t;
    typedef logic signed [0:9]  imm10_t;
    typedef logic signed [0:15] imm16_t;
    typedef logic signed [0:17] imm18_t;

    // Preload matrix rows, four single-precision floats each
    localparam quad_t PRELOAD_ROW_A  = 128'h3f800000_40000000_40400000_40800000;  // 1 2 3 4
    localparam quad_t PRELOAD_ROW_B1 = 128'h40a00000_40e00000_40a00000_40e00000;  // 5 7 5 7
    localparam quad_t PRELOAD_ROW_B2 = 128'h40c00000_41000000_40c00000_41000000;  // 6 8 6 8

    localparam reg_addr_t PRELOAD_ADDR_ROW_A = 7'd12;  // B1 and B2 follow at 13 and 14

    // Constants parked at the top of the file
    localparam quad_t PRELOAD_CONST_124 = {96'd0, 32'h408ccccd};                 // Scalar in word 3
    localparam quad_t PRELOAD_CONST_125 = 128'h00000001_00000001_00000001_00000001;  // Ones
    localparam quad_t PRELOAD_CONST_126 = 128'd170808406006153739902585569290863280256;
    localparam quad_t PRELOAD_CONST_127 = 128'd170808403787765189503184116671632670848;

    typedef struct packed {
        reg_addr_t ra;
        reg_addr_t rb;
        reg_addr_t rc;
    } operand_addr_t;  // 21 bits

    typedef struct packed {
        quad_t ra_data;
        quad_t rb_data;
        quad_t rc_data;
    } operand_data_t;  // 384 bits

    typedef struct packed {
        logic      wr_en;  // Write strobe from the pipe
        reg_addr_t rt;
        quad_t     data;
    } writeback_t;  // 136 bits

    typedef struct packed {
        opcode_t       opcode;
        reg_addr_t     rt;
        operand_addr_t src;
        imm7_t         imm7;
        imm10_t        imm10;
        imm16_t        imm16;
        imm18_t        imm18;
    } even_instr_t;  // 90 bits

    typedef struct packed {
        opcode_t       opcode;
        reg_addr_t     rt;
        operand_addr_t src;
        imm7_t         imm7;
        imm10_t        imm10;
        imm16_t        imm16;
        imm18_t        imm18;
        pc_t           pc;
        logic          flush;  // Kill request into the odd pipe
    } odd_instr_t;  // 106 bits

    typedef struct packed {
        opcode_t       opcode;
        reg_addr_t     rt;
        imm7_t         imm7;
        imm10_t        imm10;
        imm16_t        imm16;
        imm18_t        imm18;
        operand_data_t operands;
    } even_issue_t;  // 453 bits

    typedef struct packed {
        opcode_t       opcode;
        reg_addr_t     rt;
        imm7_t         imm7;
        imm10_t        imm10;
        imm16_t        imm16;
        imm18_t        imm18;
        operand_data_t operands;
        pc_t           pc;
        logic          flush;
    } odd_issue_t;  // 469 bits

endpackage

`default_nettype wire

// File: hdl/spu_regfile_top.sv
// Top level of the dual-pipe register file, register array plus operand fetch stage
`timescale 1ns/1ns
`default_nettype none

module spu_regfile_top (
    input  logic                         clk,
    input  logic                         reset,
    input  spu_regfile_pkg::even_instr_t even_instr,  // Even slot of the issue pair
    input  spu_regfile_pkg::odd_instr_t  odd_instr,   // Odd slot of the issue pair
    input  spu_regfile_pkg::writeback_t  even_wb,     // Result from external even pipe
    input  spu_regfile_pkg::writeback_t  odd_wb,      // Result from external odd pipe
    output spu_regfile_pkg::even_issue_t even_issue,  // One cycle after even_instr
    output spu_regfile_pkg::odd_issue_t  odd_issue    // One cycle after odd_instr
);
    import spu_regfile_pkg::*;

    // Read address and data between fetch stage and array
    operand_addr_t even_src;       // Even ra/rb/rc
    operand_addr_t odd_src;        // Odd ra/rb/rc
    operand_data_t even_operands;  // Combinational read result
    operand_data_t odd_operands;

    // Storage and write-back
    register_array i_register_array (
        .clk           (clk),
        .reset         (reset),          // Preload strobe
        .even_wb       (even_wb),
        .odd_wb        (odd_wb),         // Wins on same rt
        .even_src      (even_src),
        .odd_src       (odd_src),
        .even_operands (even_operands),
        .odd_operands  (odd_operands)
    );

    // Field and operand alignment into issue packets
    operand_fetch i_operand_fetch (
        .clk           (clk),
        .reset         (reset),          // Clears both packets
        .even_instr    (even_instr),
        .odd_instr     (odd_instr),
        .even_src      (even_src),
        .odd_src       (odd_src),
        .even_operands (even_operands),
        .odd_operands  (odd_operands),
        .even_issue    (even_issue),
        .odd_issue     (odd_issue)
    );

endmodule

`default_nettype wire

// File: src.f
hdl/spu_regfile_pkg.sv
hdl/register_array.sv
hdl/operand_fetch.sv
hdl/spu_regfile_top.sv
dv/spu_regfile_properties.sv
dv/tb_spu_regfile.sv
